// File: files.f
mem_bus_pkg.sv
ram_test_pkg.sv
ram_db_tester.sv
test_launcher.sv
test_collector.sv
ram_test_top.sv
tb_ram_test_top.sv

// File: tb_ram_test_top.sv
//--------------------
// Testbench for the RAM data bus test
// Per-bank RAM models, busy and stuck-bit injection, directed tests
//--------------------
module tb_ram_test_top;
    timeunit 1ns;
    timeprecision 100ps;

    import mem_bus_pkg::*;
    import ram_test_pkg::*;

    localparam int unsigned NB   = 4;               // Banks
    localparam int unsigned AW   = 8;               // Address width
    localparam int unsigned DW   = 8;               // Data width
    localparam int unsigned TMO  = 500;             // Cycle limit of every wait
    localparam logic [31:0] SEED = 32'h5dcb_5925;

    logic       reset = 1'b0;       // Clock port of the DUT
    logic       clk;                // Reset port of the DUT
    logic       run_start;
    logic       run_clear;
    bank_mask_t bank_en;
    addr_t      test_addr;
    mem_req_t   mem_req [NB];
    mem_rsp_t   mem_rsp [NB];
    logic       busy_out;
    logic       run_done;
    bank_mask_t fault_banks;
    logic [7:0] err_count;

    //--------------------
    // Model state
    //--------------------
    data_t       mem [NB][2 ** AW];
    data_t       stuck_bits [NB];   // Forced to 1 on read data
    logic        busy_mode;         // Random back-pressure on
    logic [31:0] rng;
    logic        busy_nxt [NB];     // Busy for the next cycle
    logic        new_v [NB];        // Read taken at the last posedge
    data_t       new_d [NB];
    logic        pipe_v [NB][2];    // Read latency pipe
    data_t       pipe_d [NB][2];

    data_t       wlog [NB][16];     // Accepted write data, in order
    int unsigned wr_cnt [NB];
    int unsigned rd_cnt [NB];
    int unsigned rv_cnt [NB];       // rval pulses delivered
    int unsigned rv_at_done [NB];   // rv_cnt when run_done was seen
    int unsigned req_cycles [NB];   // Cycles with any request
    int unsigned bad_addr [NB];
    int unsigned done_cnt;
    addr_t       run_addr;

    int unsigned errors;
    int unsigned test_errs;
    int unsigned tests_run;

    ram_test_top #(
        .NUM_BANKS (NB),
        .AWIDTH    (AW),
        .DWIDTH    (DW)
    ) u_ram_test_top (
        .reset       (reset),
        .clk         (clk),
        .run_start   (run_start),
        .run_clear   (run_clear),
        .bank_en     (bank_en),
        .test_addr   (test_addr),
        .mem_req     (mem_req),
        .mem_rsp     (mem_rsp),
        .busy_out    (busy_out),
        .run_done    (run_done),
        .fault_banks (fault_banks),
        .err_count   (err_count)
    );

    initial begin
        forever #50 reset = ~reset;     // 100 ns period
    end

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    //--------------------
    // RAM models
    //--------------------

    // Sees the same pre-edge values as the DUT
    always @(posedge reset) begin
        for (int b = 0; b < NB; b++) begin
            if (mem_rsp[b].rval)
                rv_cnt[b]++;
            if (mem_req[b].wreq || mem_req[b].rreq)
                req_cycles[b]++;
            if (!mem_rsp[b].busy && mem_req[b].wreq) begin
                if (mem_req[b].addr !== run_addr)
                    bad_addr[b]++;
                mem[b][mem_req[b].addr] = mem_req[b].wdat;
                if (wr_cnt[b] < 16)
                    wlog[b][wr_cnt[b]] = mem_req[b].wdat;
                wr_cnt[b]++;
            end
            if (!mem_rsp[b].busy && mem_req[b].rreq) begin
                if (mem_req[b].addr !== run_addr)
                    bad_addr[b]++;
                new_v[b] = 1'b1;
                new_d[b] = mem[b][mem_req[b].addr] | stuck_bits[b];
                rd_cnt[b]++;
            end
            rng = xorshift32(rng);
            busy_nxt[b] = busy_mode && (rng[2:0] < 3'd3);   // About 3 in 8
        end
        if (run_done === 1'b1) begin
            done_cnt++;
            for (int b = 0; b < NB; b++)
                rv_at_done[b] = rv_cnt[b];
        end
    end

    // Read taken at posedge k returns at posedge k+3
    always @(negedge reset) begin
        for (int b = 0; b < NB; b++) begin
            mem_rsp[b].rval = pipe_v[b][1];
            mem_rsp[b].rdat = pipe_d[b][1];
            pipe_v[b][1]    = pipe_v[b][0];
            pipe_d[b][1]    = pipe_d[b][0];
            pipe_v[b][0]    = new_v[b];
            pipe_d[b][0]    = new_d[b];
            new_v[b]        = 1'b0;
            mem_rsp[b].busy = busy_nxt[b];
        end
    end

    //--------------------
    // Helpers
    //--------------------
    task automatic check_eq(string test, string what, logic [31:0] exp_val,
                            logic [31:0] act_val);
        if (exp_val !== act_val) begin
            $display("[FAIL] %s: %s expected %0h, actual %0h", test, what, exp_val, act_val);
            errors++;
            test_errs++;
        end
    endtask

    task automatic timeout_fail(string test, string what);
        $display("%s: gave up after %0d cycles waiting for %s", test, TMO, what);
        errors++;
        test_errs++;
    endtask

    task automatic idle_cycles(int unsigned n);
        repeat (n) @(negedge reset);
    endtask

    task automatic clear_logs();
        for (int b = 0; b < NB; b++) begin
            wr_cnt[b]     = 0;
            rd_cnt[b]     = 0;
            rv_cnt[b]     = 0;
            rv_at_done[b] = 0;
            req_cycles[b] = 0;
            bad_addr[b]   = 0;
        end
    endtask

    task automatic pulse_start(bank_mask_t en, addr_t a);
        bank_en   = en;
        test_addr = a;
        run_start = 1'b1;
        @(negedge reset);
        run_start = 1'b0;
    endtask

    task automatic start_run(bank_mask_t en, addr_t a);
        clear_logs();
        run_addr = a;
        pulse_start(en, a);
    endtask

    task automatic pulse_clear();
        run_clear = 1'b1;
        @(negedge reset);
        run_clear = 1'b0;
    endtask

    task automatic wait_run_done(string test, int unsigned base);
        int unsigned cyc;
        cyc = 0;
        while (done_cnt == base && cyc < TMO) begin
            @(negedge reset);
            cyc++;
        end
        if (done_cnt == base)
            timeout_fail(test, "run_done");
    endtask

    task automatic wait_idle(string test);
        int unsigned cyc;
        cyc = 0;
        while (busy_out !== 1'b0 && cyc < TMO) begin
            @(negedge reset);
            cyc++;
        end
        if (busy_out !== 1'b0)
            timeout_fail(test, "busy_out to drop");
    endtask

    task automatic wait_writes(string test, int b, int unsigned n);
        int unsigned cyc;
        cyc = 0;
        while (wr_cnt[b] < n && cyc < TMO) begin
            @(negedge reset);
            cyc++;
        end
        if (wr_cnt[b] < n)
            timeout_fail(test, "bank writes");
    endtask

    // Writes 1, 2, 4 ... at run_addr and every read back before run_done
    task automatic check_walk(string test, int b);
        data_t exp_w;
        check_eq(test, $sformatf("bank %0d writes", b), DW, wr_cnt[b]);
        check_eq(test, $sformatf("bank %0d reads", b), DW, rd_cnt[b]);
        check_eq(test, $sformatf("bank %0d returns at run_done", b), DW, rv_at_done[b]);
        check_eq(test, $sformatf("bank %0d bad addresses", b), 0, bad_addr[b]);
        for (int unsigned i = 0; i < DW && i < 16; i++) begin
            exp_w = data_t'(1) << i;
            check_eq(test, $sformatf("bank %0d write %0d", b, i), exp_w, wlog[b][i]);
        end
    endtask

    // Walking-one words whose value changes under the stuck mask
    function automatic int unsigned walk_mismatches(data_t stuck);
        int unsigned n;
        data_t       w;
        n = 0;
        for (int i = 0; i < DW; i++) begin
            w = data_t'(1) << i;
            if ((w | stuck) != w)
                n++;
        end
        return n;
    endfunction

    task automatic begin_test();
        test_errs = 0;
        tests_run++;
    endtask

    task automatic end_test(string test);
        $display("%s finished, %0d error(s)", test, test_errs);
    endtask

    //--------------------
    // Directed tests
    //--------------------
    task automatic idle_after_reset();
        string t;
        t = "idle_after_reset";
        begin_test();
        clear_logs();
        idle_cycles(20);
        check_eq(t, "run_done pulses", 0, done_cnt);
        check_eq(t, "busy_out", 0, busy_out);
        check_eq(t, "fault_banks", 0, fault_banks);
        check_eq(t, "err_count", 0, err_count);
        for (int b = 0; b < NB; b++)
            check_eq(t, $sformatf("bank %0d request cycles", b), 0, req_cycles[b]);
        end_test(t);
    endtask

    // Full clean run on every bank
    task automatic run_all_banks(string t, addr_t a);
        int unsigned base;
        base = done_cnt;
        start_run('1, a);
        wait_run_done(t, base);
        idle_cycles(10);                    // No second run_done
        check_eq(t, "run_done pulses", 1, done_cnt - base);
        check_eq(t, "fault_banks", 0, fault_banks);
        check_eq(t, "err_count", 0, err_count);
        check_eq(t, "busy_out", 0, busy_out);
        for (int b = 0; b < NB; b++)
            check_walk(t, b);
    endtask

    task automatic clean_run_all();
        begin_test();
        run_all_banks("clean_run_all", 8'h3c);
        end_test("clean_run_all");
    endtask

    task automatic busy_backpressure();
        begin_test();
        busy_mode = 1'b1;
        run_all_banks("busy_backpressure", 8'hc5);
        busy_mode = 1'b0;
        end_test("busy_backpressure");
    endtask

    task automatic stuck_bit_fault();
        string       t;
        int unsigned base;
        t = "stuck_bit_fault";
        begin_test();
        stuck_bits[2] = 8'h08;              // Bit 3 stuck at 1
        base = done_cnt;
        start_run('1, 8'h5a);
        wait_run_done(t, base);
        idle_cycles(10);
        check_eq(t, "run_done pulses", 1, done_cnt - base);
        check_eq(t, "fault_banks", bank_mask_t'(1) << 2, fault_banks);
        check_eq(t, "err_count", walk_mismatches(stuck_bits[2]), err_count);
        for (int b = 0; b < NB; b++)
            check_walk(t, b);
        stuck_bits[2] = '0;
        end_test(t);
    endtask

    task automatic partial_mask();
        string       t;
        int unsigned base;
        t = "partial_mask";
        begin_test();
        base = done_cnt;
        start_run(4'b0101, 8'h81);
        idle_cycles(4);
        pulse_start(4'b1111, 8'h81);        // Ignored while the run is in progress
        wait_run_done(t, base);
        idle_cycles(10);
        check_eq(t, "run_done pulses", 1, done_cnt - base);
        check_eq(t, "fault_banks", 0, fault_banks);
        for (int b = 0; b < NB; b++) begin
            if (b == 0 || b == 2) begin
                check_walk(t, b);
            end else begin
                check_eq(t, $sformatf("bank %0d request cycles", b), 0, req_cycles[b]);
            end
        end
        end_test(t);
    endtask

    task automatic clear_mid_run();
        string       t;
        int unsigned base;
        t = "clear_mid_run";
        begin_test();
        base = done_cnt;
        stuck_bits[0] = 8'h80;              // Bank 0 faults before the abort
        start_run('1, 8'h27);
        wait_writes(t, 0, 5);
        check_eq(t, "fault_banks before clear", bank_mask_t'(1), fault_banks);
        pulse_clear();
        wait_idle(t);
        idle_cycles(12);                    // Let late reads drain
        stuck_bits[0] = '0;
        check_eq(t, "run_done pulses", 0, done_cnt - base);
        check_eq(t, "busy_out", 0, busy_out);
        check_eq(t, "fault_banks", 0, fault_banks);
        check_eq(t, "err_count", 0, err_count);
        check_eq(t, "bank 0 run cut short", 1, wr_cnt[0] < DW);
        run_all_banks(t, 8'he8);            // Fresh run after the abort
        end_test(t);
    endtask

    //--------------------
    // Main sequence
    //--------------------
    initial begin
        clk       = 1'b1;
        run_start = 1'b0;
        run_clear = 1'b0;
        bank_en   = '0;
        test_addr = '0;
        busy_mode = 1'b0;
        rng       = SEED;
        run_addr  = '0;
        done_cnt  = 0;
        errors    = 0;
        test_errs = 0;
        tests_run = 0;
        for (int b = 0; b < NB; b++) begin
            mem_rsp[b]    = '0;
            stuck_bits[b] = '0;
            busy_nxt[b]   = 1'b0;
            new_v[b]      = 1'b0;
            new_d[b]      = '0;
            for (int s = 0; s < 2; s++) begin
                pipe_v[b][s] = 1'b0;
                pipe_d[b][s] = '0;
            end
            for (int a = 0; a < 2 ** AW; a++)
                mem[b][a] = data_t'(a) ^ 8'hc3 ^ data_t'(b);   // Per-address fill
        end
        clear_logs();
        repeat (8) @(posedge reset);
        @(negedge reset);
        clk = 1'b0;

        idle_after_reset();
        clean_run_all();
        busy_backpressure();
        stuck_bit_fault();
        partial_mask();
        clear_mid_run();

        $display("Tests run: %0d, errors: %0d", tests_run, errors);
        if (errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule : tb_ram_test_top

// File: ram_test_top.sv
//--------------------
// Multi-bank RAM data bus test, launcher, testers and collector
//--------------------
module ram_test_top #(
    parameter int unsigned NUM_BANKS = 4,   // Number of RAM banks
    parameter int unsigned AWIDTH    = 8,   // Address width
    parameter int unsigned DWIDTH    = 8    // Data width
) (
    input  logic                     reset,                 // Clock
    input  logic                     clk,                   // Async reset, active high
    input  logic                     run_start,
    input  logic                     run_clear,
    input  ram_test_pkg::bank_mask_t bank_en,
    input  mem_bus_pkg::addr_t       test_addr,
    output mem_bus_pkg::mem_req_t    mem_req [NUM_BANKS],   // One bus per bank
    input  mem_bus_pkg::mem_rsp_t    mem_rsp [NUM_BANKS],
    output logic                     busy_out,
    output logic                     run_done,
    output ram_test_pkg::bank_mask_t fault_banks,
    output logic [7 : 0]             err_count
);
    import ram_test_pkg::*;

    launch_t    launch [NUM_BANKS];
    report_t    report [NUM_BANKS];
    bank_mask_t running;
    bank_mask_t launched;

    test_launcher #(
        .NUM_BANKS (NUM_BANKS),
        .AWIDTH    (AWIDTH)
    ) u_test_launcher (
        .reset      (reset),
        .clk        (clk),
        .run_start  (run_start),
        .run_clear  (run_clear),
        .bank_en    (bank_en),
        .test_addr  (test_addr),
        .running_in (running),
        .launch     (launch),
        .launched   (launched),
        .busy_out   (busy_out)
    );

    //--------------------
    // One tester per bank
    //--------------------
    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
        ram_db_tester #(
            .AWIDTH (AWIDTH),
            .DWIDTH (DWIDTH)
        ) u_ram_db_tester (
            .reset   (reset),
            .clk     (clk),
            .launch  (launch[i]),
            .rsp     (mem_rsp[i]),
            .req     (mem_req[i]),
            .report  (report[i]),
            .running (running[i])
        );
    end

    // Launched mask is nonzero only in the launch cycle
    test_collector #(
        .NUM_BANKS (NUM_BANKS)
    ) u_test_collector (
        .reset         (reset),
        .clk           (clk),
        .run_start_acc (|launched),
        .run_clear     (run_clear),
        .launched      (launched),
        .report        (report),
        .run_done      (run_done),
        .fault_banks   (fault_banks),
        .err_count     (err_count)
    );

endmodule : ram_test_top

// File: test_collector.sv
//--------------------
// Tester done and fault pulses merged into run status
//--------------------
module test_collector #(
    parameter int unsigned NUM_BANKS = 4    // Number of RAM banks
) (
    input  logic                     reset,                 // Clock
    input  logic                     clk,                   // Async reset, active high
    input  logic                     run_start_acc,         // Launch cycle
    input  logic                     run_clear,             // Abort strobe
    input  ram_test_pkg::bank_mask_t launched,              // Started banks
    input  ram_test_pkg::report_t    report [NUM_BANKS],    // Tester pulses
    output logic                     run_done,              // All launched banks done
    output ram_test_pkg::bank_mask_t fault_banks,           // Banks with any fault
    output logic [7 : 0]             err_count              // Bad words, saturating
);
    import ram_test_pkg::*;

    localparam int unsigned        CWIDTH  = $bits(err_count);
    localparam logic [CWIDTH : 0] CNT_MAX = {1'b0, {CWIDTH{1'b1}}};

    bank_mask_t        pend_mask;   // Launched, no done yet
    bank_mask_t        pend_next;
    bank_mask_t        done_vec;
    bank_mask_t        fault_vec;
    logic [CWIDTH : 0] err_sum;     // One spare bit for the overflow check

    // Gather pulses, faults only count for banks of the current run
    always_comb begin
        done_vec  = '0;
        fault_vec = '0;
        for (int i = 0; i < NUM_BANKS; i++) begin
            done_vec[i]  = report[i].done;
            fault_vec[i] = report[i].fault & pend_mask[i];
        end
    end

    assign pend_next = pend_mask & ~done_vec;

    // Several banks can fault in one cycle
    always_comb begin
        err_sum = {1'b0, err_count};
        for (int i = 0; i < NUM_BANKS; i++)
            err_sum = err_sum + (CWIDTH + 1)'(fault_vec[i]);
        if (err_sum > CNT_MAX)
            err_sum = CNT_MAX;          // Saturate at 255
    end

    //--------------------
    // Status registers
    //--------------------
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            pend_mask   <= '0;
            run_done    <= 1'b0;
            fault_banks <= '0;
            err_count   <= '0;
        end else if (run_clear) begin
            pend_mask   <= '0;          // Abort, no run_done follows
            run_done    <= 1'b0;
            fault_banks <= '0;
            err_count   <= '0;
        end else if (run_start_acc) begin
            pend_mask   <= launched;
            run_done    <= 1'b0;
            fault_banks <= '0;
            err_count   <= '0;
        end else begin
            pend_mask   <= pend_next;
            run_done    <= (|pend_mask) & ~(|pend_next);    // Last done just seen
            fault_banks <= fault_banks | fault_vec;
            err_count   <= err_sum[CWIDTH - 1 : 0];
        end
    end

endmodule : test_collector

// File: test_launcher.sv
//--------------------
// Run command latch, per-bank start and clear strobes
//--------------------
module test_launcher #(
    parameter int unsigned NUM_BANKS = 4,   // Number of RAM banks
    parameter int unsigned AWIDTH    = 8    // Address width
) (
    input  logic                     reset,                 // Clock
    input  logic                     clk,                   // Async reset, active high
    input  logic                     run_start,             // Start strobe
    input  logic                     run_clear,             // Abort strobe
    input  ram_test_pkg::bank_mask_t bank_en,               // Banks to test
    input  mem_bus_pkg::addr_t       test_addr,             // Address to test at
    input  ram_test_pkg::bank_mask_t running_in,            // Tester activity
    output ram_test_pkg::launch_t    launch [NUM_BANKS],    // Per-bank strobes
    output ram_test_pkg::bank_mask_t launched,              // Started banks, one cycle
    output logic                     busy_out               // Run in progress
);
    import ram_test_pkg::*;

    logic                  start_reg;   // Launch cycle
    logic                  clear_reg;   // Forwarded clear
    bank_mask_t            mask_reg;    // Banks of this run
    logic [AWIDTH - 1 : 0] addr_reg;    // Address of this run
    logic                  accept;

    // Launch cycle counts as busy, testers are not running yet
    assign busy_out = (|running_in) | start_reg;

    // Clear wins, empty masks are not runs
    assign accept = run_start & ~busy_out & ~run_clear & (|bank_en);

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            start_reg <= 1'b0;
            clear_reg <= 1'b0;
        end else begin
            start_reg <= accept;
            clear_reg <= run_clear;
        end
    end

    always_ff @(posedge reset) begin
        if (accept) begin
            mask_reg <= bank_en;
            addr_reg <= test_addr;
        end
    end

    assign launched = start_reg ? mask_reg : '0;    // Only in the launch cycle

    //--------------------
    // Per-bank fan-out
    //--------------------
    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_launch
        assign launch[i] = '{start: launched[i], clear: clear_reg, addr: addr_reg};
    end

endmodule : test_launcher

// File: ram_db_tester.sv
//--------------------
// Walking-ones data bus tester for one RAM bank
//--------------------
module ram_db_tester #(
    parameter int unsigned AWIDTH = 8,  // Address width
    parameter int unsigned DWIDTH = 8   // Data width
) (
    input  logic                  reset,    // Clock
    input  logic                  clk,      // Async reset, active high
    input  ram_test_pkg::launch_t launch,   // Start, clear, address
    input  mem_bus_pkg::mem_rsp_t rsp,      // From the RAM
    output mem_bus_pkg::mem_req_t req,      // To the RAM
    output ram_test_pkg::report_t report,   // Done and fault pulses
    output logic                  running   // High from st_wreq until done
);
    import ram_test_pkg::*;

    //--------------------
    // Constants and signals
    //--------------------
    localparam int unsigned      PWIDTH   = $clog2(DWIDTH + 1);       // Fits DWIDTH reads
    localparam logic [DWIDTH - 1 : 0] ONE_HOT0 = {{(DWIDTH - 1){1'b0}}, 1'b1};

    tester_state_t         state;
    logic [3 : 0]          st;          // Raw state bits for decoding
    logic [AWIDTH - 1 : 0] addr_reg;    // Address of this run
    logic [DWIDTH - 1 : 0] wdat_reg;    // Next word to write
    logic [DWIDTH - 1 : 0] exp_reg;     // Next word expected back
    logic [PWIDTH - 1 : 0] pend_cnt;    // Reads accepted, not yet returned
    logic                  wr_acc;
    logic                  rd_acc;
    logic                  rd_ret;
    logic                  rd_last;
    logic                  done_reg;
    logic                  fault_reg;

    assign st      = state;
    assign running = st[0];
    assign wr_acc  = st[1] & ~rsp.busy;     // Write taken this cycle
    assign rd_acc  = st[2] & ~rsp.busy;     // Read taken this cycle
    assign rd_ret  = st[0] & rsp.rval;      // Stale returns in idle are dropped

    // Draining and the last outstanding read is back now
    assign rd_last = st[3] & ((pend_cnt == '0) | ((pend_cnt == PWIDTH'(1)) & rsp.rval));

    //--------------------
    // FSM
    //--------------------
    always_ff @(posedge reset or posedge clk) begin
        if (clk)
            state <= st_idle;
        else if (launch.clear)
            state <= st_idle;               // Abort from any state
        else begin
            case (state)
                st_idle:
                    if (launch.start)
                        state <= st_wreq;
                st_wreq:
                    if (wr_acc)
                        state <= st_rreq;
                st_rreq:
                    if (rd_acc)
                        state <= wdat_reg[0] ? st_wait : st_wreq;  // Bit wrapped to 0
                st_wait:
                    if (rd_last)
                        state <= st_idle;
                default:
                    state <= st_idle;
            endcase
        end
    end

    // Address held for the whole run
    always_ff @(posedge reset) begin
        if ((state == st_idle) && launch.start)
            addr_reg <= launch.addr;
    end

    //--------------------
    // Pattern registers
    //--------------------
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            wdat_reg <= ONE_HOT0;
            exp_reg  <= ONE_HOT0;
        end else if (launch.clear || ((state == st_idle) && launch.start)) begin
            wdat_reg <= ONE_HOT0;
            exp_reg  <= ONE_HOT0;
        end else begin
            if (wr_acc)
                wdat_reg <= {wdat_reg[DWIDTH - 2 : 0], wdat_reg[DWIDTH - 1]};   // Rotate left
            if (rd_ret)
                exp_reg <= {exp_reg[DWIDTH - 2 : 0], exp_reg[DWIDTH - 1]};
        end
    end

    // Outstanding reads, a read and a return in one cycle cancel out
    always_ff @(posedge reset or posedge clk) begin
        if (clk)
            pend_cnt <= '0;
        else if (launch.clear)
            pend_cnt <= '0;
        else if (rd_acc && !rd_ret)
            pend_cnt <= pend_cnt + 1'b1;
        else if (!rd_acc && rd_ret)
            pend_cnt <= pend_cnt - 1'b1;
    end

    //--------------------
    // Report pulses
    //--------------------
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            done_reg  <= 1'b0;
            fault_reg <= 1'b0;
        end else if (launch.clear) begin
            done_reg  <= 1'b0;
            fault_reg <= 1'b0;
        end else begin
            done_reg  <= rd_last;                           // Same edge as return to idle
            fault_reg <= rd_ret & (rsp.rdat != exp_reg);    // One per bad word
        end
    end

    assign report = '{done: done_reg, fault: fault_reg};
    assign req    = '{addr: addr_reg, wreq: st[1], wdat: wdat_reg, rreq: st[2]};

endmodule : ram_db_tester

// File: ram_test_pkg.sv
//--------------------
// Tester FSM states, launch and report structs, bank mask
//--------------------
package ram_test_pkg;

    localparam int unsigned BANKS_DFLT = 4;             // Default bank count

    typedef logic [BANKS_DFLT - 1 : 0] bank_mask_t;     // One bit per bank

    // Bit 0 working, bit 1 write request, bit 2 read request, bit 3 drain
    typedef enum logic [3 : 0] {
        st_idle = 4'b0000,
        st_wreq = 4'b0011,
        st_rreq = 4'b0101,
        st_wait = 4'b1001
    } tester_state_t;

    // Launcher to each tester
    typedef struct packed {
        logic               start;  // Single-cycle start strobe
        logic               clear;  // Single-cycle abort back to idle
        mem_bus_pkg::addr_t addr;   // Word address under test
    } launch_t;

    // Each tester to the collector
    typedef struct packed {
        logic done;     // Test finished, one pulse
        logic fault;    // Read mismatch, one pulse per bad word
    } report_t;

endpackage : ram_test_pkg

// File: mem_bus_pkg.sv
//--------------------
// RAM word types and the per-bank request and response structs
//--------------------
package mem_bus_pkg;

    //--------------------
    // Default widths
    //--------------------
    localparam int unsigned ADDR_W = 8;     // Word address width
    localparam int unsigned DATA_W = 8;     // Data bus width

    typedef logic [ADDR_W - 1 : 0] addr_t;  // RAM word address
    typedef logic [DATA_W - 1 : 0] data_t;  // RAM data word

    //--------------------
    // Bus structs
    //--------------------

    // Tester to RAM, held unchanged while busy
    typedef struct packed {
        addr_t addr;    // Word address for both writes and reads
        logic  wreq;    // Write request
        data_t wdat;    // Write data
        logic  rreq;    // Read request
    } mem_req_t;

    // RAM to tester
    typedef struct packed {
        data_t rdat;    // Read data, valid with rval
        logic  rval;    // One pulse per accepted read, in order
        logic  busy;    // Back-pressure, nothing accepted while high
    } mem_rsp_t;

endpackage : mem_bus_pkg
